/* verilog/board_params.svh */
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// serial link, clock cycles per bit
`define CLKS_PER_BIT 8

// cycles each display digit stays lit
`define SEG_SCAN_DIV 16

// cycles each keypad column is held low
`define KP_SCAN_DIV  4

// register map
`define REG_LED1     4'd0
`define REG_LED2     4'd1
`define REG_SEG      4'd2
`define REG_KEY      4'd3   // bit 15 pending, bits 3:0 last key
`define REG_SW       4'd4   // read only

`endif

/* verilog/board_pkg.sv */
package board_pkg;

    typedef logic [15:0] reg_data_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  key_idx_t;    // column * 4 + row

    // wishbone classic, master to slave
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        reg_addr_t adr;
        reg_data_t dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic      ack;
        reg_data_t dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    typedef enum logic [2:0] {
        CMD_IDLE, CMD_DATA_HI, CMD_DATA_LO, CMD_BUS, CMD_REPLY_HI, CMD_REPLY_LO
    } cmd_state_e;

endpackage

/* verilog/uart_rx.sv */
`include "board_params.svh"

module uart_rx (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             rx,
    output board_pkg::byte_t data,
    output logic             valid
);

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(`CLKS_PER_BIT / 2 - 1);

    board_pkg::rx_state_e state;
    board_pkg::byte_t     shreg;
    logic [1:0]           rx_sync;
    logic                 rx_s;
    logic [CNT_W-1:0]     cnt;
    logic [2:0]           bit_idx;

    assign rx_s = rx_sync[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync <= 2'b11;          // line idles high
            state   <= board_pkg::RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            valid   <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            valid   <= 1'b0;
            cnt     <= cnt + 1'b1;
            case (state)
                board_pkg::RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_s) begin
                        state <= board_pkg::RX_START;
                    end
                end
                board_pkg::RX_START: begin
                    if (cnt == CNT_HALF) begin     // middle of start bit
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? board_pkg::RX_IDLE : board_pkg::RX_DATA;
                    end
                end
                board_pkg::RX_DATA: begin
                    if (cnt == CNT_LAST) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= board_pkg::RX_STOP;
                        end
                    end
                end
                board_pkg::RX_STOP: begin
                    if (cnt == CNT_LAST) begin
                        valid <= rx_s;             // low stop bit, frame dropped
                        state <= board_pkg::RX_IDLE;
                    end
                end
                default: state <= board_pkg::RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == board_pkg::RX_DATA && cnt == CNT_LAST) begin
            shreg <= {rx_s, shreg[7:1]};   // lsb arrives first
        end
    end

    assign data = shreg;

endmodule

/* verilog/uart_tx.sv */
`include "board_params.svh"

module uart_tx (
    input  logic             clk,
    input  logic             rst_n,
    input  board_pkg::byte_t data,
    input  logic             start,
    output logic             tx,
    output logic             busy
);

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CLKS_PER_BIT - 1);

    board_pkg::tx_state_e state;
    board_pkg::byte_t     shreg;
    logic [CNT_W-1:0]     cnt;
    logic [2:0]           bit_idx;
    logic                 bit_end;

    assign bit_end = (cnt == CNT_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= board_pkg::TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            cnt <= bit_end ? '0 : cnt + 1'b1;
            case (state)
                board_pkg::TX_IDLE: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (start) begin
                        state <= board_pkg::TX_START;
                    end
                end
                board_pkg::TX_START: begin
                    if (bit_end) state <= board_pkg::TX_DATA;
                end
                board_pkg::TX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= board_pkg::TX_STOP;
                    end
                end
                board_pkg::TX_STOP: begin
                    if (bit_end) state <= board_pkg::TX_IDLE;
                end
                default: state <= board_pkg::TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == board_pkg::TX_IDLE && start) begin
            shreg <= data;
        end else if (state == board_pkg::TX_DATA && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

    always_comb begin
        case (state)
            board_pkg::TX_START: tx = 1'b0;
            board_pkg::TX_DATA:  tx = shreg[0];
            default:             tx = 1'b1;   // idle and stop bit
        endcase
    end

    assign busy = (state != board_pkg::TX_IDLE);

endmodule

/* verilog/uart_bus_master.sv */
module uart_bus_master (
    input  logic               clk,
    input  logic               rst_n,
    input  board_pkg::byte_t   rx_data,
    input  logic               rx_valid,
    output board_pkg::byte_t   tx_data,
    output logic               tx_start,
    input  logic               tx_busy,
    output board_pkg::wb_req_t wb_req,
    input  board_pkg::wb_rsp_t wb_rsp
);

    board_pkg::cmd_state_e state;
    board_pkg::wb_req_t    req_q;
    board_pkg::reg_data_t  rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= board_pkg::CMD_IDLE;
            req_q <= '0;
        end else begin
            case (state)
                board_pkg::CMD_IDLE: begin
                    if (rx_valid) begin
                        req_q.adr <= rx_data[3:0];
                        req_q.we  <= rx_data[7];
                        if (rx_data[7]) begin
                            state <= board_pkg::CMD_DATA_HI;
                        end else begin
                            // read starts right away
                            req_q.cyc <= 1'b1;
                            req_q.stb <= 1'b1;
                            state     <= board_pkg::CMD_BUS;
                        end
                    end
                end
                board_pkg::CMD_DATA_HI: begin
                    if (rx_valid) begin
                        req_q.dat[15:8] <= rx_data;
                        state           <= board_pkg::CMD_DATA_LO;
                    end
                end
                board_pkg::CMD_DATA_LO: begin
                    if (rx_valid) begin
                        req_q.dat[7:0] <= rx_data;
                        req_q.cyc      <= 1'b1;
                        req_q.stb      <= 1'b1;
                        state          <= board_pkg::CMD_BUS;
                    end
                end
                board_pkg::CMD_BUS: begin
                    if (wb_rsp.ack) begin
                        req_q.cyc <= 1'b0;
                        req_q.stb <= 1'b0;
                        state <= req_q.we ? board_pkg::CMD_IDLE : board_pkg::CMD_REPLY_HI;
                    end
                end
                board_pkg::CMD_REPLY_HI: begin
                    if (tx_start) state <= board_pkg::CMD_REPLY_LO;
                end
                board_pkg::CMD_REPLY_LO: begin
                    if (tx_start) state <= board_pkg::CMD_IDLE;
                end
                default: state <= board_pkg::CMD_IDLE;
            endcase
        end
    end

    // read data held for the two reply bytes
    always_ff @(posedge clk) begin
        if (state == board_pkg::CMD_BUS && wb_rsp.ack) begin
            rdata <= wb_rsp.dat;
        end
    end

    assign wb_req   = req_q;
    assign tx_start = (state == board_pkg::CMD_REPLY_HI || state == board_pkg::CMD_REPLY_LO)
                      && !tx_busy;
    assign tx_data  = (state == board_pkg::CMD_REPLY_HI) ? rdata[15:8] : rdata[7:0];

    a_stb_held_to_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(wb_req.stb) |-> $past(wb_rsp.ack)
    ) else $error("stb dropped without ack");

    a_adr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wb_req.stb && !wb_rsp.ack) |=> $stable(wb_req.adr)
    ) else $error("adr changed during bus cycle");

endmodule

/* verilog/io_regs.sv */
`include "board_params.svh"

module io_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  board_pkg::wb_req_t   wb_req,
    output board_pkg::wb_rsp_t   wb_rsp,
    input  board_pkg::reg_data_t switches,
    input  board_pkg::key_idx_t  key_idx,
    input  logic                 key_press,
    output board_pkg::reg_data_t led1,
    output board_pkg::reg_data_t led2,
    output board_pkg::reg_data_t seg_value
);

    board_pkg::reg_data_t sw_meta;
    board_pkg::reg_data_t sw_sync;
    board_pkg::reg_data_t rd_mux;
    board_pkg::reg_data_t rdat_q;
    board_pkg::key_idx_t  key_last;
    logic                 key_pend;
    logic                 ack_q;
    logic                 access;

    // only the first cycle of a strobe, ack goes out next
    assign access = wb_req.cyc && wb_req.stb && !ack_q;

    always_ff @(posedge clk) begin
        sw_meta <= switches;
        sw_sync <= sw_meta;
    end

    always_comb begin
        case (wb_req.adr)
            `REG_LED1: rd_mux = led1;
            `REG_LED2: rd_mux = led2;
            `REG_SEG:  rd_mux = seg_value;
            `REG_KEY:  rd_mux = {key_pend, 11'b0, key_last};
            `REG_SW:   rd_mux = sw_sync;
            default:   rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q     <= 1'b0;
            led1      <= '0;
            led2      <= '0;
            seg_value <= '0;
            key_pend  <= 1'b0;
            key_last  <= '0;
        end else begin
            ack_q <= access;
            if (access && wb_req.we) begin
                case (wb_req.adr)
                    `REG_LED1: led1      <= wb_req.dat;
                    `REG_LED2: led2      <= wb_req.dat;
                    `REG_SEG:  seg_value <= wb_req.dat;
                    default:   ;   // switches, key and holes ignore writes
                endcase
            end
            if (key_press) begin
                key_pend <= 1'b1;
                key_last <= key_idx;
            end else if (access && !wb_req.we && wb_req.adr == `REG_KEY) begin
                key_pend <= 1'b0;                      // read clears pending
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdat_q <= rd_mux;
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: rdat_q};

    a_ack_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(wb_req.stb) |=> wb_rsp.ack ##1 !wb_rsp.ack
    ) else $error("ack not a single cycle right after the strobe");

endmodule

/* verilog/seg7_scan.sv */
`include "board_params.svh"

module seg7_scan (
    input  logic                 clk,
    input  logic                 rst_n,
    input  board_pkg::reg_data_t value,
    output logic [3:0]           seg_en,
    output logic [7:0]           seg_out
);

    localparam int DIV_W = $clog2(`SEG_SCAN_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SEG_SCAN_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       digit;
    logic             lit;      // display dark until first slot ends
    logic [3:0]       nibble;
    logic [6:0]       pat;      // active high, a in bit 0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            digit   <= '0;
            lit     <= 1'b0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            if (div_cnt == DIV_LAST) begin
                div_cnt <= '0;
                if (!lit) begin
                    lit <= 1'b1;
                end else begin
                    digit <= digit + 1'b1;   // wraps 3 -> 0
                end
            end
        end
    end

    assign nibble = value[4*digit +: 4];

    always_comb begin
        case (nibble)
            4'h0: pat = 7'h3F;
            4'h1: pat = 7'h06;
            4'h2: pat = 7'h5B;
            4'h3: pat = 7'h4F;
            4'h4: pat = 7'h66;
            4'h5: pat = 7'h6D;
            4'h6: pat = 7'h7D;
            4'h7: pat = 7'h07;
            4'h8: pat = 7'h7F;
            4'h9: pat = 7'h6F;
            4'hA: pat = 7'h77;
            4'hB: pat = 7'h7C;
            4'hC: pat = 7'h39;
            4'hD: pat = 7'h5E;
            4'hE: pat = 7'h79;
            default: pat = 7'h71;
        endcase
    end

    // common anode, everything active low, dp off
    assign seg_out = {1'b1, ~pat};
    assign seg_en  = lit ? ~(4'b0001 << digit) : 4'hF;

endmodule

/* verilog/keypad_scan.sv */
`include "board_params.svh"

module keypad_scan (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [3:0]          kp_row,
    output logic [3:0]          kp_col,
    output board_pkg::key_idx_t key_idx,
    output logic                key_press
);

    localparam int DIV_W = $clog2(`KP_SCAN_DIV);
    localparam logic [DIV_W-1:0] SLOT_LAST = DIV_W'(`KP_SCAN_DIV - 1);

    logic [DIV_W-1:0] slot_cnt;
    logic [1:0]       col;
    logic [3:0]       row_meta;
    logic [3:0]       row_s;
    logic             slot_end;
    logic             hit;
    logic [1:0]       row_idx;
    logic             armed;     // ready to report a new press
    logic             seen;      // some key down during this scan

    assign slot_end = (slot_cnt == SLOT_LAST);
    assign kp_col   = ~(4'b0001 << col);

    // lowest numbered low row wins
    always_comb begin
        hit     = 1'b0;
        row_idx = '0;
        for (int r = 3; r >= 0; r--) begin
            if (!row_s[r]) begin
                hit     = 1'b1;
                row_idx = 2'(r);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_meta  <= 4'hF;
            row_s     <= 4'hF;
            slot_cnt  <= '0;
            col       <= '0;
            armed     <= 1'b1;
            seen      <= 1'b0;
            key_idx   <= '0;
            key_press <= 1'b0;
        end else begin
            row_meta  <= kp_row;
            row_s     <= row_meta;
            key_press <= 1'b0;
            slot_cnt  <= slot_cnt + 1'b1;
            if (slot_end) begin
                slot_cnt <= '0;
                col      <= col + 1'b1;
                if (hit && armed) begin
                    key_press <= 1'b1;
                    key_idx   <= {col, row_idx};
                    armed     <= 1'b0;
                end
                if (col == 2'd3) begin
                    seen <= 1'b0;
                    if (!seen && !hit) begin
                        armed <= 1'b1;   // whole scan idle, rearm
                    end
                end else if (hit) begin
                    seen <= 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/board_top.sv */
module board_top (
    input  logic                 clk,
    input  logic                 rst_n,
    // serial link
    input  logic                 rx,
    output logic                 tx,
    // board devices
    input  board_pkg::reg_data_t switches,
    input  logic [3:0]           kp_row,
    output logic [3:0]           kp_col,
    output board_pkg::reg_data_t led1_out,
    output board_pkg::reg_data_t led2_out,
    output logic [3:0]           seg_en,
    output logic [7:0]           seg_out
);

    board_pkg::byte_t     rx_byte;
    board_pkg::byte_t     tx_byte;
    logic                 rx_valid;
    logic                 tx_start;
    logic                 tx_busy;
    board_pkg::wb_req_t   wb_req;
    board_pkg::wb_rsp_t   wb_rsp;
    board_pkg::reg_data_t seg_value;
    board_pkg::key_idx_t  key_idx;
    logic                 key_press;

    uart_rx uart_rx_inst (
        .clk,
        .rst_n,
        .rx,
        .data  (rx_byte),
        .valid (rx_valid)
    );

    uart_tx uart_tx_inst (
        .clk,
        .rst_n,
        .data  (tx_byte),
        .start (tx_start),
        .tx,
        .busy  (tx_busy)
    );

    // the only bus master
    uart_bus_master uart_bus_master_inst (
        .clk,
        .rst_n,
        .rx_data  (rx_byte),
        .rx_valid,
        .tx_data  (tx_byte),
        .tx_start,
        .tx_busy,
        .wb_req,
        .wb_rsp
    );

    io_regs io_regs_inst (
        .clk,
        .rst_n,
        .wb_req,
        .wb_rsp,
        .switches,
        .key_idx,
        .key_press,
        .led1      (led1_out),
        .led2      (led2_out),
        .seg_value
    );

    seg7_scan seg7_scan_inst (
        .clk,
        .rst_n,
        .value (seg_value),
        .seg_en,
        .seg_out
    );

    keypad_scan keypad_scan_inst (
        .clk,
        .rst_n,
        .kp_row,
        .kp_col,
        .key_idx,
        .key_press
    );

endmodule

/* dv/tb_board_top.sv */
`include "board_params.svh"

module tb_board_top;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_KEY} op_e;

    localparam int NUM_ROWS = 16;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 * `CLKS_PER_BIT;
    localparam board_pkg::reg_data_t SW_VALUE = 16'hC35A;
    localparam board_pkg::reg_addr_t HOLE = 4'hB;     // unused address
    // active high segment patterns for 0 to F with a in bit 0
    localparam logic [127:0] SEG_TABLE =
        128'h71_79_5E_39_7C_77_6F_7F_07_7D_6D_66_4F_5B_06_3F;

    logic                 clk;
    logic                 rst_n;
    logic                 rx;
    logic                 tx;
    board_pkg::reg_data_t switches;
    logic [3:0]           kp_row;
    logic [3:0]           kp_col;
    board_pkg::reg_data_t led1_out;
    board_pkg::reg_data_t led2_out;
    logic [3:0]           seg_en;
    logic [7:0]           seg_out;

    op_e                  tbl_op   [NUM_ROWS];
    board_pkg::reg_addr_t tbl_addr [NUM_ROWS];
    board_pkg::reg_data_t tbl_data [NUM_ROWS];
    board_pkg::reg_data_t tbl_exp  [NUM_ROWS];

    integer               seed = 8;
    int                   cycles;
    logic                 key_down;
    logic [1:0]           key_col;
    logic [1:0]           key_row;
    board_pkg::reg_data_t exp_led1;
    board_pkg::reg_data_t exp_led2;
    board_pkg::reg_data_t rd_word;

    board_top i_board_top (
        .clk,
        .rst_n,
        .rx,
        .tx,
        .switches,
        .kp_row,
        .kp_col,
        .led1_out,
        .led2_out,
        .seg_en,
        .seg_out
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // pressed key pulls its row low while its column is driven
    always_comb begin
        kp_row = (key_down && !kp_col[key_col]) ? ~(4'b0001 << key_row) : 4'hF;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) abort("timeout: no reply from board");
    end

    task automatic abort(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            abort($sformatf("CHECK FAILED: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic set_row(input int i, input op_e o, input board_pkg::reg_addr_t a,
                           input board_pkg::reg_data_t d, input board_pkg::reg_data_t e);
        tbl_op[i]   = o;
        tbl_addr[i] = a;
        tbl_data[i] = d;
        tbl_exp[i]  = e;
    endtask

    task automatic build_table;
        board_pkg::reg_data_t r_led1;
        board_pkg::reg_data_t r_led2;
        board_pkg::reg_data_t r_seg;
        board_pkg::reg_data_t r_sw;
        board_pkg::reg_data_t r_hole;
        r_led1 = $random(seed);
        r_led2 = $random(seed);
        r_seg  = $random(seed);
        r_sw   = $random(seed);
        r_hole = $random(seed);
        set_row(0,  OP_WR,  `REG_LED1, r_led1, '0);
        set_row(1,  OP_RD,  `REG_LED1, '0,     r_led1);
        set_row(2,  OP_WR,  `REG_LED2, r_led2, '0);
        set_row(3,  OP_RD,  `REG_LED2, '0,     r_led2);
        set_row(4,  OP_WR,  `REG_SEG,  r_seg,  '0);
        set_row(5,  OP_RD,  `REG_SEG,  '0,     r_seg);
        set_row(6,  OP_RD,  `REG_SW,   '0,     SW_VALUE);
        set_row(7,  OP_WR,  `REG_SW,   r_sw,   '0);     // ignored by a read-only register
        set_row(8,  OP_RD,  `REG_SW,   '0,     SW_VALUE);
        set_row(9,  OP_KEY, '0,        16'h9,  '0);     // column 2 row 1
        set_row(10, OP_RD,  `REG_KEY,  '0,     16'h8009);
        set_row(11, OP_RD,  `REG_KEY,  '0,     16'h0009);
        set_row(12, OP_RD,  HOLE,      '0,     '0);
        set_row(13, OP_WR,  HOLE,      r_hole, '0);
        set_row(14, OP_RD,  `REG_LED1, '0,     r_led1);
        set_row(15, OP_RD,  `REG_LED2, '0,     r_led2);
    endtask

    // 8N1 frame sent lsb first
    task automatic send_byte(input board_pkg::byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #5 rx = frame[i];
            repeat (`CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic recv_byte(output board_pkg::byte_t b);
        board_pkg::byte_t v;
        @(negedge clk);
        while (tx !== 1'b0) @(negedge clk);
        repeat (`CLKS_PER_BIT / 2) @(negedge clk);     // to the middle of the start bit
        if (tx !== 1'b0) abort("start bit on tx ended early");
        for (int i = 0; i < 8; i++) begin
            repeat (`CLKS_PER_BIT) @(negedge clk);
            v[i] = tx;
        end
        repeat (`CLKS_PER_BIT) @(negedge clk);
        if (tx !== 1'b1) abort("stop bit on tx is missing");
        b = v;
    endtask

    task automatic bus_write(input board_pkg::reg_addr_t a, input board_pkg::reg_data_t d);
        send_byte({4'h8, a});
        send_byte(d[15:8]);
        send_byte(d[7:0]);
    endtask

    task automatic bus_read(input board_pkg::reg_addr_t a, output board_pkg::reg_data_t d);
        board_pkg::byte_t hi;
        board_pkg::byte_t lo;
        fork
            send_byte({4'h0, a});
            begin
                recv_byte(hi);    // reply may start before the command stop bit ends
                recv_byte(lo);
            end
        join
        d = {hi, lo};
    endtask

    // each lit digit against its nibble over one full scan
    task automatic watch_scan(input board_pkg::reg_data_t value);
        logic [3:0] seen;
        logic [3:0] nib;
        int         d;
        seen = '0;
        repeat (4 * `SEG_SCAN_DIV + 1) begin
            @(negedge clk);
            case (seg_en)
                4'hE:    d = 0;
                4'hD:    d = 1;
                4'hB:    d = 2;
                4'h7:    d = 3;
                default: d = -1;
            endcase
            if (d < 0) begin
                abort("display enables do not select exactly one digit");
            end else begin
                nib = value[4*d +: 4];
                check("seg_out", seg_out, {1'b1, ~SEG_TABLE[8*nib +: 7]});
                seen[d] = 1'b1;
            end
        end
        check("digits lit", seen, 4'hF);
    endtask

    task automatic press_key(input logic [3:0] idx);
        logic [3:0] cols_seen;
        cols_seen = '0;
        key_col   = idx[3:2];
        key_row   = idx[1:0];
        @(posedge clk);
        #5 key_down = 1'b1;
        repeat (3 * 4 * `KP_SCAN_DIV) begin
            @(negedge clk);
            case (kp_col)
                4'hE:    cols_seen[0] = 1'b1;
                4'hD:    cols_seen[1] = 1'b1;
                4'hB:    cols_seen[2] = 1'b1;
                4'h7:    cols_seen[3] = 1'b1;
                default: abort("keypad does not drive exactly one column low");
            endcase
        end
        check("kp_col walk", cols_seen, 4'hF);
        @(posedge clk);
        #5 key_down = 1'b0;
        repeat (3 * 4 * `KP_SCAN_DIV) @(posedge clk);   // idle scans rearm the scanner
    endtask

    initial begin
        cycles   = 0;
        rst_n    = 1'b0;
        rx       = 1'b1;
        switches = SW_VALUE;
        key_down = 1'b0;
        key_col  = '0;
        key_row  = '0;
        exp_led1 = '0;
        exp_led2 = '0;
        build_table();
        repeat (8) @(posedge clk);
        #5 rst_n = 1'b1;

        @(negedge clk);
        check("tx", tx, 1'b1);
        check("seg_en", seg_en, 4'hF);
        check("led1_out", led1_out, '0);
        check("led2_out", led2_out, '0);

        for (int row = 0; row < NUM_ROWS; row++) begin
            case (tbl_op[row])
                OP_WR: begin
                    bus_write(tbl_addr[row], tbl_data[row]);
                    if (tbl_addr[row] == `REG_LED1) exp_led1 = tbl_data[row];
                    if (tbl_addr[row] == `REG_LED2) exp_led2 = tbl_data[row];
                    repeat (`CLKS_PER_BIT + 4) @(negedge clk);
                    check("led1_out", led1_out, exp_led1);
                    check("led2_out", led2_out, exp_led2);
                    if (tbl_addr[row] == `REG_SEG) watch_scan(tbl_data[row]);
                end
                OP_RD: begin
                    bus_read(tbl_addr[row], rd_word);
                    check("reply", rd_word, tbl_exp[row]);
                end
                default: press_key(tbl_data[row][3:0]);
            endcase
            repeat (`CLKS_PER_BIT) @(posedge clk);
        end

        $display("test passed");
        $finish;
    end

endmodule

/* src.f */
+incdir+verilog
verilog/board_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart_bus_master.sv
verilog/io_regs.sv
verilog/seg7_scan.sv
verilog/keypad_scan.sv
verilog/board_top.sv
dv/tb_board_top.sv

/* Bender.yml */
package:
  name: board_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/board_pkg.sv
      - verilog/uart_rx.sv
      - verilog/uart_tx.sv
      - verilog/uart_bus_master.sv
      - verilog/io_regs.sv
      - verilog/seg7_scan.sv
      - verilog/keypad_scan.sv
      - verilog/board_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/tb_board_top.sv
